// File: all.f
hw/rf_pkg.sv
hw/rf_wr_if.sv
hw/rf_write_decode.sv
hw/rf_bank.sv
hw/rf_read_select.sv
hw/rf_top.sv
verification/rf_chk.sv
verification/rf_tb.sv

// File: hw/rf_bank.sv
// Register bank: 32 flip-flop words with port B over port A priority
`timescale 1ns/100ps

module rf_bank (
  input  logic                   clk,
  input  logic                   rst_n,

  // Decoded strobes and data for this bank
  rf_wr_if.bank                  wr_i,

  // Current contents, read combinationally downstream
  output rf_pkg::rf_bank_words_t words_o
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  // Every word cleared on reset so reads start at zero
  // Word 0 of the integer bank is kept at zero by the decoder
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      words_o <= '0;
    end else begin
      for (int w = 0; w < rf_pkg::NUM_WORDS; w++) begin
        // Port B first, so a collision keeps B's data
        if (wr_i.wen_b[w]) begin
          words_o[w] <= wr_i.wdata_b;
        end else if (wr_i.wen_a[w]) begin
          words_o[w] <= wr_i.wdata_a;
        end
      end
    end
  end

endmodule

// File: hw/rf_pkg.sv
// Register file package: widths, bank constants and shared vector types
package rf_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------

  // Full register address, top bit picks the bank
  localparam int ADDR_W     = 6;
  // Word index inside one bank
  localparam int WORD_IDX_W = 5;
  // Register word width
  localparam int DATA_W     = 32;
  // Words held by each bank
  localparam int NUM_WORDS  = 32;

  // ------------------------------------------------------------
  // Banks
  // ------------------------------------------------------------

  // Integer bank plus floating-point bank, both always built
  localparam int NUM_BANKS  = 2;
  // Bank holding x0 to x31
  localparam int INT_BANK   = 0;
  // Bank holding f0 to f31
  localparam int FP_BANK    = 1;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  // Address as seen on the read and write ports
  typedef logic [ADDR_W-1:0]     rf_addr_t;
  // Word select within a bank
  typedef logic [WORD_IDX_W-1:0] rf_word_idx_t;
  // One register word
  typedef logic [DATA_W-1:0]     rf_data_t;
  // One-hot write strobes, one bit per word of a bank
  typedef logic [NUM_WORDS-1:0]  rf_wen_t;
  // Whole bank contents, word index first
  typedef logic [NUM_WORDS-1:0][DATA_W-1:0] rf_bank_words_t;

endpackage

// File: hw/rf_read_select.sv
// Read selector: three combinational read ports over both banks
`timescale 1ns/100ps

module rf_read_select (
  // Top address bit ignored while high
  input  logic                   fregfile_disable_i,

  // Read addresses
  input  rf_pkg::rf_addr_t       raddr_a_i,
  input  rf_pkg::rf_addr_t       raddr_b_i,
  input  rf_pkg::rf_addr_t       raddr_c_i,

  // Contents of every bank, indexed by bank
  input  rf_pkg::rf_bank_words_t bank_words_i [rf_pkg::NUM_BANKS],

  // Read data, same cycle as the address
  output rf_pkg::rf_data_t       rdata_a_o,
  output rf_pkg::rf_data_t       rdata_b_o,
  output rf_pkg::rf_data_t       rdata_c_o
);

  localparam int NUM_RPORTS = 3;

  // ------------------------------------------------------------
  // Port gathering
  // ------------------------------------------------------------

  // Ports kept in arrays so one block serves all three
  rf_pkg::rf_addr_t raddr [NUM_RPORTS];
  rf_pkg::rf_data_t rdata [NUM_RPORTS];

  assign raddr[0] = raddr_a_i;
  assign raddr[1] = raddr_b_i;
  assign raddr[2] = raddr_c_i;

  assign rdata_a_o = rdata[0];
  assign rdata_b_o = rdata[1];
  assign rdata_c_o = rdata[2];

  // ------------------------------------------------------------
  // Word select
  // ------------------------------------------------------------

  for (genvar p = 0; p < NUM_RPORTS; p++) begin : g_rport
    // Resolved bank and word for this port
    logic                 fp_sel;
    rf_pkg::rf_word_idx_t word;

    // Bank bit masked by the disable, same rule as the write side
    assign fp_sel = raddr[p][rf_pkg::ADDR_W-1] & ~fregfile_disable_i;
    assign word   = raddr[p][rf_pkg::WORD_IDX_W-1:0];

    // No bypass: a same-cycle write shows up one cycle later
    always_comb begin
      if (fp_sel) begin
        rdata[p] = bank_words_i[rf_pkg::FP_BANK][word];
      end else begin
        rdata[p] = bank_words_i[rf_pkg::INT_BANK][word];
      end
    end
  end

endmodule

// File: hw/rf_top.sv
// Register file top: integer and FP banks with three reads and two writes
`timescale 1ns/100ps

module rf_top (
  input  logic             clk,
  input  logic             rst_n,

  // High folds every access onto the integer bank
  input  logic             fregfile_disable_i,

  // Read port A
  input  rf_pkg::rf_addr_t raddr_a_i,
  output rf_pkg::rf_data_t rdata_a_o,

  // Read port B
  input  rf_pkg::rf_addr_t raddr_b_i,
  output rf_pkg::rf_data_t rdata_b_o,

  // Read port C
  input  rf_pkg::rf_addr_t raddr_c_i,
  output rf_pkg::rf_data_t rdata_c_o,

  // Write port A
  input  rf_pkg::rf_addr_t waddr_a_i,
  input  rf_pkg::rf_data_t wdata_a_i,
  input  logic             we_a_i,

  // Write port B, wins a collision with port A
  input  rf_pkg::rf_addr_t waddr_b_i,
  input  rf_pkg::rf_data_t wdata_b_i,
  input  logic             we_b_i
);

  // ------------------------------------------------------------
  // Internal connections
  // ------------------------------------------------------------

  // Decoder to bank write paths, one per bank
  rf_wr_if wr_if [rf_pkg::NUM_BANKS] ();

  // Bank contents toward the read selector
  rf_pkg::rf_bank_words_t bank_words [rf_pkg::NUM_BANKS];

  // ------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------

  rf_write_decode u_write_decode (
    .fregfile_disable_i (fregfile_disable_i),
    .waddr_a_i          (waddr_a_i),
    .wdata_a_i          (wdata_a_i),
    .we_a_i             (we_a_i),
    .waddr_b_i          (waddr_b_i),
    .wdata_b_i          (wdata_b_i),
    .we_b_i             (we_b_i),
    .wr_o               (wr_if)
  );

  // ------------------------------------------------------------
  // Storage banks
  // ------------------------------------------------------------

  // Bank 0 integer, bank 1 floating point
  for (genvar b = 0; b < rf_pkg::NUM_BANKS; b++) begin : g_bank
    rf_bank u_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_i    (wr_if[b]),
      .words_o (bank_words[b])
    );
  end

  // ------------------------------------------------------------
  // Read select
  // ------------------------------------------------------------

  rf_read_select u_read_select (
    .fregfile_disable_i (fregfile_disable_i),
    .raddr_a_i          (raddr_a_i),
    .raddr_b_i          (raddr_b_i),
    .raddr_c_i          (raddr_c_i),
    .bank_words_i       (bank_words),
    .rdata_a_o          (rdata_a_o),
    .rdata_b_o          (rdata_b_o),
    .rdata_c_o          (rdata_c_o)
  );

endmodule

// File: hw/rf_wr_if.sv
// Write interface carrying one bank's decoded strobes and write data
`timescale 1ns/100ps

interface rf_wr_if;

  // ------------------------------------------------------------
  // Per-bank write request
  // ------------------------------------------------------------

  // Port A word strobes, at most one bit set
  rf_pkg::rf_wen_t  wen_a;
  // Port B word strobes, wins over port A on the same word
  rf_pkg::rf_wen_t  wen_b;

  // Data for port A, shared by every bank
  rf_pkg::rf_data_t wdata_a;
  // Data for port B
  rf_pkg::rf_data_t wdata_b;

  // Decoder side
  modport dec (
    output wen_a,
    output wen_b,
    output wdata_a,
    output wdata_b
  );

  // Storage side, strobes act on the next rising edge
  modport bank (
    input  wen_a,
    input  wen_b,
    input  wdata_a,
    input  wdata_b
  );

endinterface

// File: hw/rf_write_decode.sv
// Write decoder: resolves both write addresses into per-bank word strobes
`timescale 1ns/100ps

module rf_write_decode (
  // Top address bit ignored while high
  input  logic                fregfile_disable_i,

  // Write port A
  input  rf_pkg::rf_addr_t    waddr_a_i,
  input  rf_pkg::rf_data_t    wdata_a_i,
  input  logic                we_a_i,

  // Write port B
  input  rf_pkg::rf_addr_t    waddr_b_i,
  input  rf_pkg::rf_data_t    wdata_b_i,
  input  logic                we_b_i,

  // One write interface per bank
  rf_wr_if.dec                wr_o [rf_pkg::NUM_BANKS]
);

  // ------------------------------------------------------------
  // Address resolution
  // ------------------------------------------------------------

  // Port targets the FP bank
  logic                 fp_sel_a;
  logic                 fp_sel_b;
  // Word index within the chosen bank
  rf_pkg::rf_word_idx_t word_a;
  rf_pkg::rf_word_idx_t word_b;

  // Bank bit only counts while the FP bank is on
  assign fp_sel_a = waddr_a_i[rf_pkg::ADDR_W-1] & ~fregfile_disable_i;
  assign fp_sel_b = waddr_b_i[rf_pkg::ADDR_W-1] & ~fregfile_disable_i;

  assign word_a = waddr_a_i[rf_pkg::WORD_IDX_W-1:0];
  assign word_b = waddr_b_i[rf_pkg::WORD_IDX_W-1:0];

  // ------------------------------------------------------------
  // Strobe decode
  // ------------------------------------------------------------

  // One-hot strobe of one port for one bank
  function automatic rf_pkg::rf_wen_t decode_wen(
    input logic                 we,
    input logic                 fp_sel,
    input rf_pkg::rf_word_idx_t word,
    input int                   bank
  );
    int              tgt_bank;
    rf_pkg::rf_wen_t wen;
    tgt_bank = fp_sel ? rf_pkg::FP_BANK : rf_pkg::INT_BANK;
    wen      = '0;
    // Only the addressed bank sees the strobe
    if (we && (tgt_bank == bank)) begin
      wen[word] = 1'b1;
    end
    // x0 is hardwired to zero, never let it be written
    if (bank == rf_pkg::INT_BANK) begin
      wen[0] = 1'b0;
    end
    return wen;
  endfunction

  // Fan both ports out to every bank
  for (genvar b = 0; b < rf_pkg::NUM_BANKS; b++) begin : g_bank_wr
    assign wr_o[b].wen_a   = decode_wen(we_a_i, fp_sel_a, word_a, b);
    assign wr_o[b].wen_b   = decode_wen(we_b_i, fp_sel_b, word_b, b);
    // Data is common, the strobes pick the target
    assign wr_o[b].wdata_a = wdata_a_i;
    assign wr_o[b].wdata_b = wdata_b_i;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  -f all.f \
  --top-module rf_tb \
  -Mdir "$BUILD_DIR" \
  -o Vrf_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD_DIR/Vrf_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "Run result: pass"
  exit 0
else
  echo "Run result: fail, see $LOG"
  exit 1
fi

// File: verification/rf_chk.sv
// Assertion checker for the register file, bound into the top level
`timescale 1ns/100ps

module rf_chk (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   fregfile_disable_i,
  input rf_pkg::rf_addr_t       raddr_a_i,
  input rf_pkg::rf_addr_t       raddr_b_i,
  input rf_pkg::rf_addr_t       raddr_c_i,
  input rf_pkg::rf_data_t       rdata_a_o,
  input rf_pkg::rf_data_t       rdata_b_o,
  input rf_pkg::rf_data_t       rdata_c_o,
  input rf_pkg::rf_addr_t       waddr_a_i,
  input rf_pkg::rf_addr_t       waddr_b_i,
  input rf_pkg::rf_data_t       wdata_b_i,
  input logic                   we_a_i,
  input logic                   we_b_i,
  // Bank contents straight from the storage
  input rf_pkg::rf_bank_words_t int_words_i,
  input rf_pkg::rf_bank_words_t fp_words_i
);

  // Failure counts, one per assertion
  int fail_x0   = 0;
  int fail_rst  = 0;
  int fail_coll = 0;

  // ------------------------------------------------------------
  // Helper decode
  // ------------------------------------------------------------

  // Read port addresses x0 after the bank bit is masked
  logic x0_a;
  logic x0_b;
  logic x0_c;
  assign x0_a = (raddr_a_i[4:0] == '0) && (!raddr_a_i[5] || fregfile_disable_i);
  assign x0_b = (raddr_b_i[4:0] == '0) && (!raddr_b_i[5] || fregfile_disable_i);
  assign x0_c = (raddr_c_i[4:0] == '0) && (!raddr_c_i[5] || fregfile_disable_i);

  // Both write ports on one writable word
  logic                 fp_a;
  logic                 fp_b;
  logic                 coll;
  assign fp_a = waddr_a_i[5] & ~fregfile_disable_i;
  assign fp_b = waddr_b_i[5] & ~fregfile_disable_i;
  assign coll = we_a_i && we_b_i && (fp_a == fp_b) && (waddr_a_i[4:0] == waddr_b_i[4:0])
             && (fp_b || waddr_b_i[4:0] != '0);

  // Collision target held for one cycle
  logic                 coll_q;
  logic                 coll_fp_q;
  rf_pkg::rf_word_idx_t coll_word_q;
  rf_pkg::rf_data_t     coll_data_q;
  rf_pkg::rf_data_t     coll_rd;
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coll_q      <= 1'b0;
      coll_fp_q   <= 1'b0;
      coll_word_q <= '0;
      coll_data_q <= '0;
    end else begin
      coll_q      <= coll;
      coll_fp_q   <= fp_b;
      coll_word_q <= waddr_b_i[4:0];
      coll_data_q <= wdata_b_i;
    end
  end
  assign coll_rd = coll_fp_q ? fp_words_i[coll_word_q] : int_words_i[coll_word_q];

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------

  a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (!x0_a || rdata_a_o == '0) && (!x0_b || rdata_b_o == '0) && (!x0_c || rdata_c_o == '0))
    else begin
      $error("x0 read returned a nonzero word");
      fail_x0++;
    end

  a_zero_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (rdata_a_o == '0 && rdata_b_o == '0 && rdata_c_o == '0))
    else begin
      $error("read data not zero after reset release");
      fail_rst++;
    end

  a_port_b_wins: assert property (@(posedge clk) disable iff (!rst_n)
    coll_q |-> (coll_rd == coll_data_q))
    else begin
      $error("write collision did not keep port B data");
      fail_coll++;
    end

endmodule

bind rf_top rf_chk u_rf_chk (
  .clk                (clk),
  .rst_n              (rst_n),
  .fregfile_disable_i (fregfile_disable_i),
  .raddr_a_i          (raddr_a_i),
  .raddr_b_i          (raddr_b_i),
  .raddr_c_i          (raddr_c_i),
  .rdata_a_o          (rdata_a_o),
  .rdata_b_o          (rdata_b_o),
  .rdata_c_o          (rdata_c_o),
  .waddr_a_i          (waddr_a_i),
  .waddr_b_i          (waddr_b_i),
  .wdata_b_i          (wdata_b_i),
  .we_a_i             (we_a_i),
  .we_b_i             (we_b_i),
  .int_words_i        (bank_words[rf_pkg::INT_BANK]),
  .fp_words_i         (bank_words[rf_pkg::FP_BANK])
);

// File: verification/rf_tb.sv
// Register file testbench: random traffic checked against a reference model
`timescale 1ns/100ps

module rf_tb;

  // ------------------------------------------------------------
  // Run length
  // ------------------------------------------------------------

  localparam int RESET_CYCLES   = 2;
  localparam int N_RESET_RD     = 8;
  localparam int N_RANDOM       = 300;
  localparam int N_X0           = 24;
  // Collision and separation rounds take two cycles each
  localparam int N_COLL         = 24;
  localparam int N_SEP          = 16;
  localparam int N_DIS          = 48;
  // Every test cycle, including the FP fill and read-back of the last test
  localparam int TOTAL_CYCLES   = RESET_CYCLES + N_RESET_RD + N_RANDOM + N_X0 + 1
                                + 2 * N_COLL + 2 * N_SEP + 2 * rf_pkg::NUM_WORDS + N_DIS;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

  // DUT ports
  logic             clk;
  logic             rst_n;
  logic             fregfile_disable_i;
  rf_pkg::rf_addr_t raddr_a_i;
  rf_pkg::rf_addr_t raddr_b_i;
  rf_pkg::rf_addr_t raddr_c_i;
  rf_pkg::rf_data_t rdata_a_o;
  rf_pkg::rf_data_t rdata_b_o;
  rf_pkg::rf_data_t rdata_c_o;
  rf_pkg::rf_addr_t waddr_a_i;
  rf_pkg::rf_data_t wdata_a_i;
  logic             we_a_i;
  rf_pkg::rf_addr_t waddr_b_i;
  rf_pkg::rf_data_t wdata_b_i;
  logic             we_b_i;

  // Bookkeeping
  integer seed;
  int     cyc_cnt = 0;
  int     n_checks;
  int     n_errors;
  int     err_mark;
  int     tests_ok;
  int     tests_bad;
  int     asrt_fails;

  // Reference model, indexed by bank then word
  rf_pkg::rf_data_t model [rf_pkg::NUM_BANKS][rf_pkg::NUM_WORDS];
  // Write presented this cycle, it lands on the next rising edge
  logic             pend_we_a;
  logic             pend_we_b;
  logic             pend_dis;
  rf_pkg::rf_addr_t pend_wa_a;
  rf_pkg::rf_addr_t pend_wa_b;
  rf_pkg::rf_data_t pend_wd_a;
  rf_pkg::rf_data_t pend_wd_b;
  // FP words written before the disabled phase
  rf_pkg::rf_data_t fp_saved [rf_pkg::NUM_WORDS];

  rf_top u_rf_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .fregfile_disable_i (fregfile_disable_i),
    .raddr_a_i          (raddr_a_i),
    .rdata_a_o          (rdata_a_o),
    .raddr_b_i          (raddr_b_i),
    .rdata_b_o          (rdata_b_o),
    .raddr_c_i          (raddr_c_i),
    .rdata_c_o          (rdata_c_o),
    .waddr_a_i          (waddr_a_i),
    .wdata_a_i          (wdata_a_i),
    .we_a_i             (we_a_i),
    .waddr_b_i          (waddr_b_i),
    .wdata_b_i          (wdata_b_i),
    .we_b_i             (we_b_i)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  // Run guard
  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Random sources and reference model
  // ------------------------------------------------------------

  function automatic rf_pkg::rf_data_t random_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic rf_pkg::rf_addr_t random_addr();
    logic [31:0] r;
    r = $random(seed);
    return r[rf_pkg::ADDR_W-1:0];
  endfunction

  // Random address in the upper half, f0 to f31 when the FP bank is on
  function automatic rf_pkg::rf_addr_t high_addr();
    rf_pkg::rf_addr_t a;
    a = random_addr();
    a[rf_pkg::ADDR_W-1] = 1'b1;
    return a;
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // Bank bit counts only while the FP bank is enabled
  function automatic logic fp_bank_of(input rf_pkg::rf_addr_t addr, input logic dis);
    return addr[rf_pkg::ADDR_W-1] & ~dis;
  endfunction

  function automatic rf_pkg::rf_data_t model_read(input rf_pkg::rf_addr_t addr, input logic dis);
    return model[fp_bank_of(addr, dis)][addr[rf_pkg::WORD_IDX_W-1:0]];
  endfunction

  function automatic void model_write(input rf_pkg::rf_addr_t addr,
                                      input rf_pkg::rf_data_t data, input logic dis);
    logic                 fp;
    rf_pkg::rf_word_idx_t word;
    fp   = fp_bank_of(addr, dis);
    word = addr[rf_pkg::WORD_IDX_W-1:0];
    // x0 drops every write
    if (fp || word != '0) begin
      model[fp][word] = data;
    end
  endfunction

  // ------------------------------------------------------------
  // Checking and cycle driver
  // ------------------------------------------------------------

  task automatic compare(input string name, input rf_pkg::rf_data_t exp,
                         input rf_pkg::rf_data_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error: %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // One cycle: drive on the rising edge, check reads at the falling edge
  task automatic step(
    input logic we_a, input rf_pkg::rf_addr_t wa_a, input rf_pkg::rf_data_t wd_a,
    input logic we_b, input rf_pkg::rf_addr_t wa_b, input rf_pkg::rf_data_t wd_b,
    input rf_pkg::rf_addr_t ra_a, input rf_pkg::rf_addr_t ra_b,
    input rf_pkg::rf_addr_t ra_c, input logic dis
  );
    @(posedge clk);
    // Last cycle's write lands now, port B applied last so it wins
    if (pend_we_a) begin
      model_write(pend_wa_a, pend_wd_a, pend_dis);
    end
    if (pend_we_b) begin
      model_write(pend_wa_b, pend_wd_b, pend_dis);
    end
    we_a_i             <= we_a;
    waddr_a_i          <= wa_a;
    wdata_a_i          <= wd_a;
    we_b_i             <= we_b;
    waddr_b_i          <= wa_b;
    wdata_b_i          <= wd_b;
    raddr_a_i          <= ra_a;
    raddr_b_i          <= ra_b;
    raddr_c_i          <= ra_c;
    fregfile_disable_i <= dis;
    pend_we_a = we_a;
    pend_wa_a = wa_a;
    pend_wd_a = wd_a;
    pend_we_b = we_b;
    pend_wa_b = wa_b;
    pend_wd_b = wd_b;
    pend_dis  = dis;
    // No bypass, so the model still holds the old word here
    @(negedge clk);
    compare("rdata_a_o", model_read(ra_a, dis), rdata_a_o);
    compare("rdata_b_o", model_read(ra_b, dis), rdata_b_o);
    compare("rdata_c_o", model_read(ra_c, dis), rdata_c_o);
  endtask

  task automatic idle_read(input rf_pkg::rf_addr_t ra_a, input rf_pkg::rf_addr_t ra_b);
    step(1'b0, '0, '0, 1'b0, '0, '0, ra_a, ra_b, random_addr(), 1'b0);
  endtask

  function automatic void start_test();
    err_mark = n_errors;
  endfunction

  function automatic void end_test(input string name);
    if (n_errors == err_mark) begin
      tests_ok++;
      $display("Test %s: ok", name);
    end else begin
      tests_bad++;
      $display("Test %s: %0d mismatches", name, n_errors - err_mark);
    end
  endfunction

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic random_traffic();
    rf_pkg::rf_addr_t wa_a;
    rf_pkg::rf_addr_t wa_b;
    rf_pkg::rf_addr_t last_a;
    rf_pkg::rf_addr_t last_b;
    last_a = '0;
    last_b = '0;
    repeat (N_RANDOM) begin
      wa_a = random_addr();
      wa_b = random_addr();
      // Often read back last cycle's targets, one cycle write-to-read
      step(coin(), wa_a, random_word(), coin(), wa_b, random_word(),
           coin() ? last_a : random_addr(), coin() ? last_b : random_addr(),
           random_addr(), 1'b0);
      last_a = wa_a;
      last_b = wa_b;
    end
  endtask

  task automatic x0_writes();
    logic             dis;
    rf_pkg::rf_addr_t zero_a;
    repeat (N_X0) begin
      dis = coin();
      // With the FP bank off 0x20 also lands on x0
      zero_a = {dis & coin(), 5'b0};
      step(coin(), zero_a, random_word(), 1'b1, zero_a, random_word(),
           zero_a, random_addr(), '0, dis);
      compare("rdata_a_o", '0, rdata_a_o);
    end
    idle_read('0, '0);
    compare("rdata_a_o", '0, rdata_a_o);
  endtask

  task automatic write_collision();
    rf_pkg::rf_addr_t addr;
    rf_pkg::rf_data_t data_b;
    repeat (N_COLL) begin
      addr = random_addr();
      if (addr[rf_pkg::WORD_IDX_W-1:0] == '0) begin
        addr[0] = 1'b1;
      end
      data_b = random_word();
      step(1'b1, addr, random_word(), 1'b1, addr, data_b,
           random_addr(), random_addr(), random_addr(), 1'b0);
      idle_read(addr, random_addr());
      compare("rdata_a_o", data_b, rdata_a_o);
    end
  endtask

  task automatic bank_separation();
    rf_pkg::rf_addr_t x_addr;
    rf_pkg::rf_addr_t f_addr;
    rf_pkg::rf_data_t data_x;
    rf_pkg::rf_data_t data_f;
    repeat (N_SEP) begin
      x_addr = random_addr();
      x_addr[rf_pkg::ADDR_W-1] = 1'b0;
      if (x_addr == '0) begin
        x_addr[0] = 1'b1;
      end
      // Same word index, other bank
      f_addr = {1'b1, x_addr[rf_pkg::WORD_IDX_W-1:0]};
      data_x = random_word();
      data_f = random_word();
      step(1'b1, x_addr, data_x, 1'b1, f_addr, data_f,
           random_addr(), random_addr(), random_addr(), 1'b0);
      idle_read(x_addr, f_addr);
      compare("rdata_a_o", data_x, rdata_a_o);
      compare("rdata_b_o", data_f, rdata_b_o);
    end
  endtask

  task automatic disabled_fp_bank();
    // Known contents in every FP word
    for (int w = 0; w < rf_pkg::NUM_WORDS; w++) begin
      fp_saved[w] = random_word();
      step(1'b1, {1'b1, w[4:0]}, fp_saved[w], 1'b0, '0, '0,
           random_addr(), random_addr(), random_addr(), 1'b0);
    end
    // Upper addresses now fold onto the integer bank
    repeat (N_DIS) begin
      step(coin(), high_addr(), random_word(), coin(), high_addr(), random_word(),
           high_addr(), high_addr(), random_addr(), 1'b1);
    end
    // FP bank back on, its words untouched
    for (int w = 0; w < rf_pkg::NUM_WORDS; w++) begin
      idle_read({1'b1, w[4:0]}, random_addr());
      compare("rdata_a_o", fp_saved[w], rdata_a_o);
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    seed               = 32'h5085f8da;
    clk                = 1'b0;
    rst_n              = 1'b0;
    fregfile_disable_i = 1'b0;
    raddr_a_i          = '0;
    raddr_b_i          = '0;
    raddr_c_i          = '0;
    waddr_a_i          = '0;
    wdata_a_i          = '0;
    we_a_i             = 1'b0;
    waddr_b_i          = '0;
    wdata_b_i          = '0;
    we_b_i             = 1'b0;
    pend_we_a          = 1'b0;
    pend_we_b          = 1'b0;
    pend_dis           = 1'b0;
    pend_wa_a          = '0;
    pend_wa_b          = '0;
    pend_wd_a          = '0;
    pend_wd_b          = '0;
    n_checks           = 0;
    n_errors           = 0;
    err_mark           = 0;
    tests_ok           = 0;
    tests_bad          = 0;
    // Reset leaves every word at zero
    for (int b = 0; b < rf_pkg::NUM_BANKS; b++) begin
      for (int w = 0; w < rf_pkg::NUM_WORDS; w++) begin
        model[b][w] = '0;
      end
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    start_test();
    repeat (N_RESET_RD) idle_read(random_addr(), random_addr());
    end_test("reset");
    start_test();
    random_traffic();
    end_test("random traffic");
    start_test();
    x0_writes();
    end_test("x0");
    start_test();
    write_collision();
    end_test("write collision");
    start_test();
    bank_separation();
    end_test("bank separation");
    start_test();
    disabled_fp_bank();
    end_test("disabled fp bank");

    asrt_fails = u_rf_top.u_rf_chk.fail_x0 + u_rf_top.u_rf_chk.fail_rst
               + u_rf_top.u_rf_chk.fail_coll;
    $display("Summary: %0d tests ok, %0d tests with errors, %0d checks, %0d assertion failures",
             tests_ok, tests_bad, n_checks, asrt_fails);
    if (tests_bad == 0 && asrt_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
